// ==== cache_addr_pkg.sv ====
// Cache address and data types

`include "cache_settings.svh"

package cache_addr_pkg;

  // field widths derived from the geometry
  localparam int ADDR_W   = `CACHE_ADDR_W;
  localparam int WORD_W   = `CACHE_WORD_W;
  localparam int STRB_W   = WORD_W / 8;
  localparam int LINE_W   = `CACHE_LINE_BYTES * 8;
  localparam int SETS     = `CACHE_SETS;
  localparam int WAYS     = `CACHE_WAYS;
  localparam int BEATS    = `CACHE_BEATS;
  localparam int OFFSET_W = $clog2(`CACHE_LINE_BYTES);
  localparam int INDEX_W  = $clog2(SETS);
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
  localparam int BEAT_W   = $clog2(BEATS);  // upper offset bits
  localparam int WAY_W    = $clog2(WAYS);

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [BEAT_W-1:0]   beat_t;
  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [STRB_W-1:0]   strb_t;
  typedef logic [LINE_W-1:0]   line_t;
  typedef logic [WAY_W-1:0]    way_t;

endpackage

// ==== cache_ctrl.sv ====
// Cache controller
`timescale 1ns/1ps

module cache_ctrl (
  input  logic                      i_clk,
  input  logic                      i_rst,
  // processor request
  input  logic                      i_valid,
  input  cache_ctrl_pkg::cache_op_e i_op,
  input  cache_addr_pkg::addr_t     i_addr,
  input  cache_addr_pkg::strb_t     i_wstrb,
  input  cache_addr_pkg::word_t     i_wdata,
  output logic                      o_addr_ok,
  output logic                      o_data_ok,
  // tag array results
  input  logic                      i_hit,
  input  logic                      i_victim_dirty,
  input  cache_addr_pkg::tag_t      i_victim_tag,
  // array control
  output cache_addr_pkg::index_t    o_index,
  output cache_addr_pkg::tag_t      o_tag,
  output cache_addr_pkg::beat_t     o_beat,
  output logic                      o_store_en,
  output cache_addr_pkg::strb_t     o_wstrb,
  output cache_addr_pkg::word_t     o_wdata,
  output logic                      o_fill_en,
  output cache_addr_pkg::beat_t     o_fill_beat,
  output logic                      o_refill_done,
  // memory bus
  output logic                      o_rd_req,
  output cache_addr_pkg::addr_t     o_rd_addr,
  input  logic                      i_rd_rdy,
  input  logic                      i_ret_valid,
  input  logic                      i_ret_last,
  output logic                      o_wr_req,
  output cache_addr_pkg::addr_t     o_wr_addr,
  input  logic                      i_wr_rdy
);
  import cache_addr_pkg::*;
  import cache_ctrl_pkg::*;

  cache_state_e state_q;
  cache_state_e state_d;
  cache_op_e    req_op_q;
  addr_t        req_addr_q;
  strb_t        req_wstrb_q;
  word_t        req_wdata_q;
  beat_t        beat_cnt_q;
  logic         accept;
  logic         beat_in;

  // --------------------------------------------------
  // request register
  // --------------------------------------------------
  assign accept = i_valid && o_addr_ok;

  always_ff @(posedge i_clk) begin
    if (accept) begin
      req_op_q    <= i_op;
      req_addr_q  <= i_addr;
      req_wstrb_q <= i_wstrb;
      req_wdata_q <= i_wdata;
    end
  end

  assign o_tag   = req_addr_q[ADDR_W-1 -: TAG_W];
  assign o_index = req_addr_q[OFFSET_W +: INDEX_W];
  assign o_beat  = req_addr_q[OFFSET_W-1 -: BEAT_W];  // word within line
  assign o_wstrb = req_wstrb_q;
  assign o_wdata = req_wdata_q;

  // --------------------------------------------------
  // main state machine
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:    if (i_valid) state_d = ST_LOOKUP;
      ST_LOOKUP:  state_d = i_hit ? ST_IDLE : ST_MISS;
      ST_MISS:    if (!i_victim_dirty || i_wr_rdy) state_d = ST_REPLACE;  // clean skips writeback
      ST_REPLACE: if (i_rd_rdy) state_d = ST_REFILL;
      ST_REFILL:  if (i_ret_valid && i_ret_last) state_d = ST_LOOKUP;  // lookup now hits
      default:    state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------------------------------------
  // refill beat counter
  // --------------------------------------------------
  assign beat_in = (state_q == ST_REFILL) && i_ret_valid;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      beat_cnt_q <= '0;
    end else if ((state_q == ST_REPLACE) && i_rd_rdy) begin
      beat_cnt_q <= '0;  // entering refill
    end else if (beat_in) begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
    end
  end

  // --------------------------------------------------
  // processor and array strobes
  // --------------------------------------------------
  assign o_addr_ok     = (state_q == ST_IDLE);
  assign o_data_ok     = (state_q == ST_LOOKUP) && i_hit;
  assign o_store_en    = o_data_ok && (req_op_q == OP_WRITE);  // write hit merge
  assign o_fill_en     = beat_in;
  assign o_fill_beat   = beat_cnt_q;
  assign o_refill_done = beat_in && i_ret_last;

  // full-line bus requests
  assign o_rd_req  = (state_q == ST_REPLACE);
  assign o_rd_addr = {o_tag, o_index, {OFFSET_W{1'b0}}};
  assign o_wr_req  = (state_q == ST_MISS) && i_victim_dirty;
  assign o_wr_addr = {i_victim_tag, o_index, {OFFSET_W{1'b0}}};

endmodule

// ==== cache_ctrl_pkg.sv ====
// Cache controller types

package cache_ctrl_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cache_op_e;

  typedef enum logic [2:0] {
    ST_IDLE    = 3'd0,  // waiting for a request
    ST_LOOKUP  = 3'd1,  // tag compare on the held request
    ST_MISS    = 3'd2,  // victim writeback if dirty
    ST_REPLACE = 3'd3,  // line read request
    ST_REFILL  = 3'd4   // collecting refill beats
  } cache_state_e;

endpackage

// ==== cache_data_array.sv ====
// Cache data array
`timescale 1ns/1ps

module cache_data_array (
  input  logic                   i_clk,
  input  cache_addr_pkg::index_t i_index,
  input  cache_addr_pkg::beat_t  i_beat,
  input  cache_addr_pkg::way_t   i_hit_way,
  input  cache_addr_pkg::way_t   i_victim_way,
  // store path
  input  logic                   i_store_en,
  input  cache_addr_pkg::strb_t  i_wstrb,
  input  cache_addr_pkg::word_t  i_wdata,
  // refill path
  input  logic                   i_fill_en,
  input  cache_addr_pkg::beat_t  i_fill_beat,
  input  cache_addr_pkg::word_t  i_fill_data,
  // read results
  output cache_addr_pkg::word_t  o_rdata,
  output cache_addr_pkg::line_t  o_victim_line
);
  import cache_addr_pkg::*;

  word_t data_q [SETS][WAYS][BEATS];  // one word per beat

  // --------------------------------------------------
  // writes
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_store_en) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (i_wstrb[b]) begin
          data_q[i_index][i_hit_way][i_beat][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
    if (i_fill_en) begin
      data_q[i_index][i_victim_way][i_fill_beat] <= i_fill_data;  // whole word per beat
    end
  end

  // --------------------------------------------------
  // reads
  // --------------------------------------------------
  assign o_rdata = data_q[i_index][i_hit_way][i_beat];

  // beat 0 sits in the low bits of the line
  always_comb begin
    for (int k = 0; k < BEATS; k++) begin
      o_victim_line[k*WORD_W +: WORD_W] = data_q[i_index][i_victim_way][k];
    end
  end

endmodule

// ==== cache_settings.svh ====
// Cache geometry settings

`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// --------------------------------------------------
// address and data widths
// --------------------------------------------------
`define CACHE_ADDR_W      32  // physical byte address
`define CACHE_WORD_W      64  // processor word

// --------------------------------------------------
// organisation
// --------------------------------------------------
`define CACHE_LINE_BYTES  32  // bytes per line
`define CACHE_SETS        16
`define CACHE_WAYS        2   // two-way set associative

// words per line and refill burst length
`define CACHE_BEATS       (`CACHE_LINE_BYTES / (`CACHE_WORD_W / 8))

`endif

// ==== cache_tag_array.sv ====
// Cache tag array
`timescale 1ns/1ps

module cache_tag_array (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  cache_addr_pkg::index_t i_index,
  input  cache_addr_pkg::tag_t   i_tag,
  input  logic                   i_store_en,
  input  logic                   i_refill_done,
  output logic                   o_hit,
  output cache_addr_pkg::way_t   o_hit_way,
  output cache_addr_pkg::way_t   o_victim_way,
  output logic                   o_victim_dirty,
  output cache_addr_pkg::tag_t   o_victim_tag
);
  import cache_addr_pkg::*;

  tag_t                         tag_q [SETS][WAYS];
  logic [SETS-1:0][WAYS-1:0]    valid_q;
  logic [SETS-1:0][WAYS-1:0]    dirty_q;
  way_t                         repl_q;   // alternating replacement pointer
  logic [WAYS-1:0]              way_hit;

  // --------------------------------------------------
  // hit compare and victim choice
  // --------------------------------------------------
  always_comb begin
    way_hit   = '0;
    o_hit_way = '0;
    for (int w = 0; w < WAYS; w++) begin
      way_hit[w] = valid_q[i_index][w] && (tag_q[i_index][w] == i_tag);
      if (way_hit[w]) o_hit_way = way_t'(w);
    end
  end

  assign o_hit = |way_hit;

  always_comb begin
    o_victim_way = repl_q;  // both ways valid
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (!valid_q[i_index][w]) o_victim_way = way_t'(w);  // lowest invalid way wins
    end
  end

  assign o_victim_dirty = valid_q[i_index][o_victim_way] && dirty_q[i_index][o_victim_way];
  assign o_victim_tag   = tag_q[i_index][o_victim_way];

  // --------------------------------------------------
  // state update
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q <= '0;
      dirty_q <= '0;
      repl_q  <= '0;
    end else begin
      if (i_store_en) begin
        dirty_q[i_index][o_hit_way] <= 1'b1;
      end
      if (i_refill_done) begin
        valid_q[i_index][o_victim_way] <= 1'b1;
        dirty_q[i_index][o_victim_way] <= 1'b0;  // fresh line from memory
        repl_q                         <= repl_q + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_refill_done) begin
      tag_q[i_index][o_victim_way] <= i_tag;
    end
  end

endmodule

// ==== l1_cache.f ====
+incdir+.
cache_addr_pkg.sv
cache_ctrl_pkg.sv
cache_ctrl.sv
cache_tag_array.sv
cache_data_array.sv
l1_cache.sv
tb_l1_cache.sv

// ==== l1_cache.sv ====
// L1 data cache top
`timescale 1ns/1ps

module l1_cache (
  input  logic                      i_clk,
  input  logic                      i_rst,
  // processor port
  input  logic                      i_valid,
  input  cache_ctrl_pkg::cache_op_e i_op,
  input  cache_addr_pkg::addr_t     i_addr,
  input  cache_addr_pkg::strb_t     i_wstrb,
  input  cache_addr_pkg::word_t     i_wdata,
  output logic                      o_addr_ok,
  output logic                      o_data_ok,
  output cache_addr_pkg::word_t     o_rdata,
  // read channel
  output logic                      o_rd_req,
  output cache_addr_pkg::addr_t     o_rd_addr,
  input  logic                      i_rd_rdy,
  input  logic                      i_ret_valid,
  input  logic                      i_ret_last,
  input  cache_addr_pkg::word_t     i_ret_data,
  // write channel
  output logic                      o_wr_req,
  output cache_addr_pkg::addr_t     o_wr_addr,
  output cache_addr_pkg::line_t     o_wr_data,
  input  logic                      i_wr_rdy
);
  import cache_addr_pkg::*;

  index_t index;
  tag_t   tag;
  beat_t  beat;
  logic   store_en;
  strb_t  store_strb;
  word_t  store_data;
  logic   fill_en;
  beat_t  fill_beat;
  logic   refill_done;
  logic   hit;
  way_t   hit_way;
  way_t   victim_way;
  logic   victim_dirty;
  tag_t   victim_tag;

  cache_ctrl u_ctrl (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_valid        (i_valid),
    .i_op           (i_op),
    .i_addr         (i_addr),
    .i_wstrb        (i_wstrb),
    .i_wdata        (i_wdata),
    .o_addr_ok      (o_addr_ok),
    .o_data_ok      (o_data_ok),
    .i_hit          (hit),
    .i_victim_dirty (victim_dirty),
    .i_victim_tag   (victim_tag),
    .o_index        (index),
    .o_tag          (tag),
    .o_beat         (beat),
    .o_store_en     (store_en),
    .o_wstrb        (store_strb),
    .o_wdata        (store_data),
    .o_fill_en      (fill_en),
    .o_fill_beat    (fill_beat),
    .o_refill_done  (refill_done),
    .o_rd_req       (o_rd_req),
    .o_rd_addr      (o_rd_addr),
    .i_rd_rdy       (i_rd_rdy),
    .i_ret_valid    (i_ret_valid),
    .i_ret_last     (i_ret_last),
    .o_wr_req       (o_wr_req),
    .o_wr_addr      (o_wr_addr),
    .i_wr_rdy       (i_wr_rdy)
  );

  cache_tag_array u_tag (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_index        (index),
    .i_tag          (tag),
    .i_store_en     (store_en),
    .i_refill_done  (refill_done),
    .o_hit          (hit),
    .o_hit_way      (hit_way),
    .o_victim_way   (victim_way),
    .o_victim_dirty (victim_dirty),
    .o_victim_tag   (victim_tag)
  );

  cache_data_array u_data (
    .i_clk          (i_clk),
    .i_index        (index),
    .i_beat         (beat),
    .i_hit_way      (hit_way),
    .i_victim_way   (victim_way),
    .i_store_en     (store_en),
    .i_wstrb        (store_strb),
    .i_wdata        (store_data),
    .i_fill_en      (fill_en),
    .i_fill_beat    (fill_beat),
    .i_fill_data    (i_ret_data),   // refill beats straight from the bus
    .o_rdata        (o_rdata),
    .o_victim_line  (o_wr_data)     // writeback line
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f l1_cache.f --top-module tb_l1_cache -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_l1_cache)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

// ==== tb_l1_cache.sv ====
// L1 cache testbench
`timescale 1ns/1ps
`include "cache_settings.svh"

module tb_l1_cache;
  import cache_addr_pkg::*;
  import cache_ctrl_pkg::*;

  localparam int N_ROWS     = 10;
  localparam int MEM_WORDS  = 4096;  // 32 KB of backing memory
  localparam int ROW_CYCLES = 60;
  localparam int FLUSH_WAYS = 3;     // new lines read into each written set

  typedef struct packed {
    cache_op_e op;
    addr_t     addr;
    strb_t     strb;
    word_t     wdata;
    word_t     exp;  // read result, or merged word for writes
    logic      hit;  // hit expected one edge after acceptance
  } row_t;

  logic      i_clk;
  logic      i_rst;
  logic      i_valid;
  cache_op_e i_op;
  addr_t     i_addr;
  strb_t     i_wstrb;
  word_t     i_wdata;
  logic      o_addr_ok;
  logic      o_data_ok;
  word_t     o_rdata;
  logic      o_rd_req;
  addr_t     o_rd_addr;
  logic      i_rd_rdy;
  logic      i_ret_valid;
  logic      i_ret_last;
  word_t     i_ret_data;
  logic      o_wr_req;
  addr_t     o_wr_addr;
  line_t     o_wr_data;
  logic      i_wr_rdy;

  row_t   rows [N_ROWS];
  word_t  mem [MEM_WORDS];
  integer seed = 32'h9a90;
  int     cycles = 0;
  int     cycle_limit;
  int     n_pass = 0;
  int     n_fail = 0;
  int     test_errs = 0;

  l1_cache DUT (.*);

  initial i_clk = 1'b0;
  always #50 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: the cache stopped responding after %0d cycles", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic word_t initial_word(addr_t a);
    return {35'h0, a[31:3]} ^ 64'h5a5a_0000_0000_0000;  // word address xor pattern
  endfunction

  task automatic fill_table();
    rows[0] = '{OP_READ,  32'h0000_0040, 8'h00, 64'h0, 64'h5a5a_0000_0000_0008, 1'b0};
    rows[1] = '{OP_READ,  32'h0000_0040, 8'h00, 64'h0, 64'h5a5a_0000_0000_0008, 1'b1};
    rows[2] = '{OP_WRITE, 32'h0000_0048, 8'h0f, 64'h1111_2222_3333_4444,
                64'h5a5a_0000_3333_4444, 1'b1};
    rows[3] = '{OP_READ,  32'h0000_0048, 8'h00, 64'h0, 64'h5a5a_0000_3333_4444, 1'b1};
    rows[4] = '{OP_WRITE, 32'h0000_1010, 8'hf0, 64'haaaa_bbbb_cccc_dddd,
                64'haaaa_bbbb_0000_0202, 1'b0};  // write allocate
    rows[5] = '{OP_READ,  32'h0000_1010, 8'h00, 64'h0, 64'haaaa_bbbb_0000_0202, 1'b1};
    // three lines of set 3 where the third evicts the dirty one
    rows[6] = '{OP_WRITE, 32'h0000_0060, 8'hff, 64'h0123_4567_89ab_cdef,
                64'h0123_4567_89ab_cdef, 1'b0};
    rows[7] = '{OP_READ,  32'h0000_0260, 8'h00, 64'h0, 64'h5a5a_0000_0000_004c, 1'b0};
    rows[8] = '{OP_READ,  32'h0000_0460, 8'h00, 64'h0, 64'h5a5a_0000_0000_008c, 1'b0};
    rows[9] = '{OP_READ,  32'h0000_0060, 8'h00, 64'h0, 64'h0123_4567_89ab_cdef, 1'b0};
  endtask

  task automatic show_error(input string name, input word_t got, input word_t exp);
    $display("Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
    test_errs++;
  endtask

  task automatic finish_test(input string desc);
    if (test_errs == 0) begin
      n_pass++;
      $display("test %0d %s: ok", n_pass + n_fail, desc);
    end else begin
      n_fail++;
      $display("test %0d %s: %0d errors", n_pass + n_fail, desc, test_errs);
    end
    test_errs = 0;
  endtask

  // --------------------------------------------------
  // memory model
  // --------------------------------------------------
  task automatic serve_write();
    logic [11:0] widx;
    repeat (2) @(posedge i_clk);
    #1;
    i_wr_rdy = 1'b1;
    for (int b = 0; b < `CACHE_BEATS; b++) begin
      widx      = {o_wr_addr[14:5], beat_t'(b)};
      mem[widx] = o_wr_data[b*WORD_W +: WORD_W];  // beat 0 in the low bits
    end
    @(posedge i_clk);
    #1;
    i_wr_rdy = 1'b0;
  endtask

  task automatic serve_read();
    logic [9:0] line_idx;
    repeat (2) @(posedge i_clk);
    #1;
    i_rd_rdy = 1'b1;
    line_idx = o_rd_addr[14:5];
    @(posedge i_clk);
    #1;
    i_rd_rdy = 1'b0;
    for (int b = 0; b < `CACHE_BEATS; b++) begin
      if (($random(seed) & 3) == 0) begin
        i_ret_valid = 1'b0;  // one idle cycle
        @(posedge i_clk);
        #1;
      end
      i_ret_valid = 1'b1;
      i_ret_last  = (b == `CACHE_BEATS - 1);
      i_ret_data  = mem[{line_idx, beat_t'(b)}];
      @(posedge i_clk);
      #1;
    end
    i_ret_valid = 1'b0;
    i_ret_last  = 1'b0;
  endtask

  initial begin
    forever begin
      @(posedge i_clk);
      #1;
      if (o_wr_req) begin
        serve_write();
      end else if (o_rd_req) begin
        serve_read();
      end
    end
  end

  // --------------------------------------------------
  // processor requests
  // --------------------------------------------------
  task automatic run_request(input cache_op_e op, input addr_t addr, input strb_t strb,
                             input word_t wdata, output word_t rdata, output int edges);
    while (!o_addr_ok) begin
      @(posedge i_clk);
      #1;
    end
    i_valid = 1'b1;
    i_op    = op;
    i_addr  = addr;
    i_wstrb = strb;
    i_wdata = wdata;
    @(posedge i_clk);  // accepting edge
    #1;
    i_valid = 1'b0;
    edges   = 1;
    @(negedge i_clk);
    while (!o_data_ok) begin
      @(negedge i_clk);
      edges++;
    end
    rdata = o_rdata;
    @(posedge i_clk);
    #1;
  endtask

  initial begin
    word_t rdata;
    int    edges;
    int    n_writes;
    addr_t faddr;
    i_rst       = 1'b1;
    i_valid     = 1'b0;
    i_op        = OP_READ;
    i_addr      = '0;
    i_wstrb     = '0;
    i_wdata     = '0;
    i_rd_rdy    = 1'b0;
    i_ret_valid = 1'b0;
    i_ret_last  = 1'b0;
    i_ret_data  = '0;
    i_wr_rdy    = 1'b0;
    fill_table();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = initial_word(addr_t'(i) << 3);
    end
    n_writes = 0;
    for (int r = 0; r < N_ROWS; r++) begin
      if (rows[r].op == OP_WRITE) begin
        n_writes++;
      end
    end
    cycle_limit = 8 + (N_ROWS + FLUSH_WAYS * n_writes) * ROW_CYCLES;
    repeat (8) @(posedge i_clk);
    #1;
    i_rst = 1'b0;

    @(negedge i_clk);  // idle levels before the first request
    if (o_rd_req !== 1'b0) show_error("o_rd_req", {63'h0, o_rd_req}, 64'h0);
    if (o_wr_req !== 1'b0) show_error("o_wr_req", {63'h0, o_wr_req}, 64'h0);
    if (o_data_ok !== 1'b0) show_error("o_data_ok", {63'h0, o_data_ok}, 64'h0);
    if (o_addr_ok !== 1'b1) show_error("o_addr_ok", {63'h0, o_addr_ok}, 64'h1);
    finish_test("outputs after reset");
    @(posedge i_clk);
    #1;

    for (int r = 0; r < N_ROWS; r++) begin
      run_request(rows[r].op, rows[r].addr, rows[r].strb, rows[r].wdata, rdata, edges);
      if (rows[r].op == OP_READ && rdata !== rows[r].exp)
        show_error("o_rdata", rdata, rows[r].exp);
      if (rows[r].hit && edges != 1)
        show_error("o_data_ok edges after accept", word_t'(edges), 64'd1);
      finish_test($sformatf("%s %h", (rows[r].op == OP_WRITE) ? "write" : "read",
                            rows[r].addr));
    end

    // push every written line out to memory
    for (int r = 0; r < N_ROWS; r++) begin
      if (rows[r].op == OP_WRITE) begin
        for (int k = 0; k < FLUSH_WAYS; k++) begin
          faddr = 32'h2000 + addr_t'(k) * 32'h200 + (rows[r].addr & 32'h1e0);
          run_request(OP_READ, faddr, '0, '0, rdata, edges);
          if (rdata !== initial_word(faddr))
            show_error("o_rdata", rdata, initial_word(faddr));
        end
      end
    end
    finish_test("flush reads");
    for (int r = 0; r < N_ROWS; r++) begin
      if (rows[r].op == OP_WRITE && mem[rows[r].addr[14:3]] !== rows[r].exp)
        show_error($sformatf("mem[%h]", rows[r].addr), mem[rows[r].addr[14:3]], rows[r].exp);
    end
    finish_test("memory after flush");

    $display("tests: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
